// ==== files.f ====
rtl/l2cache_pkg.sv
rtl/l2cache_rbuf.sv
rtl/l2cache_array.sv
rtl/l2cache_replace.sv
rtl/l2cache_fsm.sv
rtl/l2cache.sv
verif/l2cache_mem_model.sv
verif/l2cache_tb.sv

// ==== rtl/l2cache.sv ====
`timescale 1ns/1ps

module l2cache import l2cache_pkg::*; #(
    parameter int index_width = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        icache_req,
    input  logic [31:0] icache_addr,
    output logic        icache_addr_ok,
    output logic        icache_data_ok,
    output line_t       icache_rdata,
    input  logic        dcache_req,
    input  l1_req_t     dcache_info,
    output logic        dcache_addr_ok,
    output logic        dcache_data_ok,
    output line_t       dcache_rdata,
    output logic        mem_req_r,
    output logic [31:0] mem_addr_r,
    input  logic        mem_addr_ok_r,
    output logic        mem_req_w,
    output logic [31:0] mem_addr_w,
    output line_t       mem_wdata,
    input  logic        mem_addr_ok_w,
    input  logic        mem_data_ok,
    input  line_t       mem_rdata
);

    logic                   idle;
    rbuf_t                  rbuf;
    logic                   rbuf_load;
    logic [index_width-1:0] index;
    logic [NUM_WAYS-1:0]    tag_we;
    tag_entry_t             tag_wdata;
    tag_entry_t             tag_rdata [NUM_WAYS];
    logic [NUM_WAYS-1:0]    line_we;
    line_t                  line_wdata;
    line_t                  line_rdata [NUM_WAYS];
    way_t                   victim;
    logic                   touch;
    way_t                   touch_way;
    line_t                  rdata;

    // both L1 ports see the same returned line
    assign icache_rdata = rdata;
    assign dcache_rdata = rdata;

    l2cache_rbuf rbuf_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .icache_req     (icache_req),
        .icache_addr    (icache_addr),
        .dcache_req     (dcache_req),
        .dcache_info    (dcache_info),
        .idle           (idle),
        .icache_addr_ok (icache_addr_ok),
        .dcache_addr_ok (dcache_addr_ok),
        .rbuf           (rbuf),
        .rbuf_load      (rbuf_load)
    );

    l2cache_array #(
        .elem_t      (tag_entry_t),
        .index_width (index_width)
    ) tag_array_i (
        .clk   (clk),
        .raddr (index),
        .we    (tag_we),
        .waddr (index),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    l2cache_array #(
        .elem_t      (line_t),
        .index_width (index_width)
    ) line_array_i (
        .clk   (clk),
        .raddr (index),
        .we    (line_we),
        .waddr (index),
        .wdata (line_wdata),
        .rdata (line_rdata)
    );

    l2cache_replace #(
        .index_width (index_width)
    ) replace_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .index     (index),
        .valid     ({tag_rdata[3].valid, tag_rdata[2].valid,
                     tag_rdata[1].valid, tag_rdata[0].valid}),
        .src       (rbuf.src),
        .touch     (touch),
        .touch_way (touch_way),
        .victim    (victim)
    );

    l2cache_fsm #(
        .index_width (index_width)
    ) fsm_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .rbuf           (rbuf),
        .rbuf_load      (rbuf_load),
        .tag_rdata      (tag_rdata),
        .line_rdata     (line_rdata),
        .victim         (victim),
        .mem_addr_ok_r  (mem_addr_ok_r),
        .mem_addr_ok_w  (mem_addr_ok_w),
        .mem_data_ok    (mem_data_ok),
        .mem_rdata      (mem_rdata),
        .idle           (idle),
        .icache_data_ok (icache_data_ok),
        .dcache_data_ok (dcache_data_ok),
        .rdata          (rdata),
        .index          (index),
        .tag_we         (tag_we),
        .tag_wdata      (tag_wdata),
        .line_we        (line_we),
        .line_wdata     (line_wdata),
        .touch          (touch),
        .touch_way      (touch_way),
        .mem_req_r      (mem_req_r),
        .mem_addr_r     (mem_addr_r),
        .mem_req_w      (mem_req_w),
        .mem_addr_w     (mem_addr_w),
        .mem_wdata      (mem_wdata)
    );

endmodule

// ==== rtl/l2cache_array.sv ====
`timescale 1ns/1ps

module l2cache_array import l2cache_pkg::*; #(
    parameter type elem_t      = logic [31:0],
    parameter int  index_width = 2
) (
    input  logic                   clk,
    input  logic [index_width-1:0] raddr,
    input  logic [NUM_WAYS-1:0]    we,
    input  logic [index_width-1:0] waddr,
    input  elem_t                  wdata,
    output elem_t                  rdata [NUM_WAYS]
);

    localparam int SETS = 1 << index_width;

    // one memory per way, all ways share the index
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        elem_t mem [SETS];

        always_ff @(posedge clk) begin
            if (we[w]) begin
                mem[waddr] <= wdata;
            end
        end

        // registered read
        always_ff @(posedge clk) begin
            rdata[w] <= mem[raddr];
        end
    end

endmodule

// ==== rtl/l2cache_fsm.sv ====
`timescale 1ns/1ps

module l2cache_fsm import l2cache_pkg::*; #(
    parameter int index_width = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rbuf_t                  rbuf,
    input  logic                   rbuf_load,
    input  tag_entry_t             tag_rdata [NUM_WAYS],
    input  line_t                  line_rdata [NUM_WAYS],
    input  way_t                   victim,
    input  logic                   mem_addr_ok_r,
    input  logic                   mem_addr_ok_w,
    input  logic                   mem_data_ok,
    input  line_t                  mem_rdata,
    output logic                   idle,
    output logic                   icache_data_ok,
    output logic                   dcache_data_ok,
    output line_t                  rdata,
    output logic [index_width-1:0] index,
    output logic [NUM_WAYS-1:0]    tag_we,
    output tag_entry_t             tag_wdata,
    output logic [NUM_WAYS-1:0]    line_we,
    output line_t                  line_wdata,
    output logic                   touch,
    output way_t                   touch_way,
    output logic                   mem_req_r,
    output logic [31:0]            mem_addr_r,
    output logic                   mem_req_w,
    output logic [31:0]            mem_addr_w,
    output line_t                  mem_wdata
);

    typedef enum logic [2:0] {
        S_SWEEP,
        S_IDLE,
        S_READ,
        S_COMPARE,
        S_WB,
        S_REFILL,
        S_REREAD
    } state_t;

    state_t                  state;
    state_t                  state_next;
    logic [index_width-1:0]  sweep_idx;
    way_t                    victim_q;
    logic [TAG_WIDTH-1:0]    rbuf_tag;
    logic [index_width-1:0]  rbuf_index;
    logic [OFFSET_WIDTH-1:0] rbuf_word;
    logic                    hit;
    way_t                    hit_way;
    line_t                   hit_line;
    logic                    victim_dirty;
    logic                    wb_done;
    logic                    refill_done;

    function automatic line_t merge_word(input line_t base,
                                         input logic [OFFSET_WIDTH-1:0] word,
                                         input logic [31:0] wdata,
                                         input logic [3:0] wstrb);
        line_t merged;
        merged = base;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                merged[word][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return merged;
    endfunction

    assign rbuf_tag   = rbuf.req.addr[31:OFFSET_WIDTH+2];
    assign rbuf_index = rbuf.req.addr[OFFSET_WIDTH+2 +: index_width];
    assign rbuf_word  = rbuf.req.addr[2 +: OFFSET_WIDTH];

    // lookup may hit in any of the four ways
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!hit && tag_rdata[w].valid && tag_rdata[w].tag == rbuf_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_line     = line_rdata[hit_way];
    assign rdata        = hit_line;
    assign victim_dirty = tag_rdata[victim].valid & tag_rdata[victim].dirty;

    // memory may answer data in the same cycle as its addr_ok
    assign wb_done     = mem_data_ok & (~mem_req_w | mem_addr_ok_w);
    assign refill_done = mem_data_ok & (~mem_req_r | mem_addr_ok_r);

    assign mem_addr_r = {rbuf_tag, {(OFFSET_WIDTH+2){1'b0}}};
    assign mem_addr_w = {tag_rdata[victim_q].tag, {(OFFSET_WIDTH+2){1'b0}}};
    assign mem_wdata  = line_rdata[victim_q];

    assign idle = (state == S_IDLE);

    always_comb begin
        state_next     = state;
        index          = rbuf_index;
        tag_we         = '0;
        tag_wdata      = '{valid: 1'b1, dirty: 1'b1, tag: rbuf_tag};
        line_we        = '0;
        line_wdata     = merge_word(hit_line, rbuf_word, rbuf.req.wdata, rbuf.req.wstrb);
        touch          = 1'b0;
        touch_way      = hit_way;
        icache_data_ok = 1'b0;
        dcache_data_ok = 1'b0;
        case (state)
            S_SWEEP: begin
                // invalidate every way of one set per cycle
                index     = sweep_idx;
                tag_we    = '1;
                tag_wdata = '0;
                if (sweep_idx == '1) begin
                    state_next = S_IDLE;
                end
            end
            S_IDLE: begin
                if (rbuf_load) begin
                    state_next = S_READ;
                end
            end
            S_READ, S_REREAD: begin
                state_next = S_COMPARE;
            end
            S_COMPARE: begin
                if (hit) begin
                    touch          = 1'b1;
                    icache_data_ok = (rbuf.src == SRC_INST);
                    dcache_data_ok = (rbuf.src == SRC_DATA);
                    if (rbuf.req.wr) begin
                        line_we[hit_way] = 1'b1;
                        tag_we[hit_way]  = 1'b1;
                    end
                    state_next = S_IDLE;
                end else if (victim_dirty) begin
                    state_next = S_WB;
                end else begin
                    state_next = S_REFILL;
                end
            end
            S_WB: begin
                if (wb_done) begin
                    state_next = S_REFILL;
                end
            end
            S_REFILL: begin
                if (refill_done) begin
                    line_we[victim_q] = 1'b1;
                    tag_we[victim_q]  = 1'b1;
                    tag_wdata.dirty   = rbuf.req.wr;
                    if (rbuf.req.wr) begin
                        line_wdata = merge_word(mem_rdata, rbuf_word,
                                                rbuf.req.wdata, rbuf.req.wstrb);
                    end else begin
                        line_wdata = mem_rdata;
                    end
                    state_next = S_REREAD;
                end
            end
            default: begin
                state_next = S_SWEEP;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_SWEEP;
            sweep_idx <= '0;
            victim_q  <= '0;
            mem_req_r <= 1'b0;
            mem_req_w <= 1'b0;
        end else begin
            state <= state_next;
            if (state == S_SWEEP) begin
                sweep_idx <= sweep_idx + 1'b1;
            end
            if (state == S_COMPARE) begin
                victim_q <= victim;
            end
            // memory requests stay high until their addr_ok
            if (mem_addr_ok_w) begin
                mem_req_w <= 1'b0;
            end else if (state != S_WB && state_next == S_WB) begin
                mem_req_w <= 1'b1;
            end
            if (mem_addr_ok_r) begin
                mem_req_r <= 1'b0;
            end else if (state != S_REFILL && state_next == S_REFILL) begin
                mem_req_r <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/l2cache_pkg.sv ====
package l2cache_pkg;

    // line geometry, L1 and L2 lines are the same size
    localparam int LINE_WORDS   = 4;
    localparam int OFFSET_WIDTH = 2;
    localparam int NUM_WAYS     = 4;
    localparam int TAG_WIDTH    = 32 - OFFSET_WIDTH - 2;

    typedef logic [LINE_WORDS-1:0][31:0] line_t;

    // data-side request, one word with byte strobes
    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } l1_req_t;

    typedef enum logic {
        SRC_INST = 1'b0,
        SRC_DATA = 1'b1
    } req_src_t;

    typedef struct packed {
        req_src_t src;
        l1_req_t  req;
    } rbuf_t;

    // tag holds the full line address, so it does not depend on the set count
    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    typedef logic [1:0] way_t;

endpackage

// ==== rtl/l2cache_rbuf.sv ====
`timescale 1ns/1ps

module l2cache_rbuf import l2cache_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        icache_req,
    input  logic [31:0] icache_addr,
    input  logic        dcache_req,
    input  l1_req_t     dcache_info,
    input  logic        idle,
    output logic        icache_addr_ok,
    output logic        dcache_addr_ok,
    output rbuf_t       rbuf,
    output logic        rbuf_load
);

    l1_req_t     sel_req;
    req_src_t    src_q;
    logic        wr_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic [3:0]  wstrb_q;

    // data side has priority
    assign dcache_addr_ok = idle & dcache_req;
    assign icache_addr_ok = idle & icache_req & ~dcache_req;
    assign rbuf_load      = dcache_addr_ok | icache_addr_ok;

    // instruction fetch is a plain read
    always_comb begin
        if (dcache_req) begin
            sel_req = dcache_info;
        end else begin
            sel_req = '{wr: 1'b0, addr: icache_addr, wdata: '0, wstrb: '0};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            src_q <= SRC_INST;
            wr_q  <= 1'b0;
        end else if (rbuf_load) begin
            src_q <= dcache_req ? SRC_DATA : SRC_INST;
            wr_q  <= sel_req.wr;
        end
    end

    always_ff @(posedge clk) begin
        if (rbuf_load) begin
            addr_q  <= sel_req.addr;
            wdata_q <= sel_req.wdata;
            wstrb_q <= sel_req.wstrb;
        end
    end

    assign rbuf = '{src: src_q,
                    req: '{wr: wr_q, addr: addr_q, wdata: wdata_q, wstrb: wstrb_q}};

endmodule

// ==== rtl/l2cache_replace.sv ====
`timescale 1ns/1ps

module l2cache_replace import l2cache_pkg::*; #(
    parameter int index_width = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [index_width-1:0] index,
    input  logic [NUM_WAYS-1:0]    valid,
    input  req_src_t               src,
    input  logic                   touch,
    input  way_t                   touch_way,
    output way_t                   victim
);

    localparam int SETS = 1 << index_width;

    // per set, bit h names the less recently used way of pair h
    logic [SETS-1:0][1:0] lru;
    logic                 half;
    logic [1:0]           half_valid;

    // instruction side owns ways 0-1, data side ways 2-3
    assign half       = (src == SRC_DATA);
    assign half_valid = half ? valid[3:2] : valid[1:0];

    always_comb begin
        if (!half_valid[0]) begin
            victim = {half, 1'b0};
        end else if (!half_valid[1]) begin
            victim = {half, 1'b1};
        end else begin
            victim = {half, lru[index][half]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru <= '0;
        end else if (touch) begin
            lru[index][touch_way[1]] <= ~touch_way[0];
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the L2 cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f files.f --top-module l2cache_tb \
        -Mdir obj_dir -o l2cache_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/l2cache_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi

exit 0

// ==== verif/l2cache_mem_model.sv ====
`timescale 1ns/1ps

module l2cache_mem_model import l2cache_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_req_r,
    input  logic [31:0] mem_addr_r,
    output logic        mem_addr_ok_r,
    input  logic        mem_req_w,
    input  logic [31:0] mem_addr_w,
    input  line_t       mem_wdata,
    output logic        mem_addr_ok_w,
    output logic        mem_data_ok,
    output line_t       mem_rdata,
    output int          rd_count,
    output int          wb_count,
    output logic [31:0] last_wb_addr,
    output line_t       last_wb_line
);

    // written-back lines, keyed by line address
    line_t       store [logic [31:0]];
    logic [31:0] rng;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic line_t unwritten_line(input logic [31:0] base);
        line_t l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w] = (base + 32'(w * 4)) ^ 32'h5A5A_0000;
        end
        return l;
    endfunction

    // 1 to 8 cycles until addr_ok
    task automatic wait_latency();
        int n;
        rng = xorshift(rng);
        n   = int'(rng[2:0]);
        repeat (n) @(negedge clk);
    endtask

    // data_ok in the addr_ok cycle or up to 3 cycles later
    task automatic send_data_ok();
        int gap;
        rng = xorshift(rng);
        gap = int'(rng[5:4]);
        if (gap == 0) begin
            mem_data_ok = 1'b1;
        end
        @(negedge clk);
        mem_addr_ok_r = 1'b0;
        mem_addr_ok_w = 1'b0;
        if (gap != 0) begin
            repeat (gap - 1) @(negedge clk);
            mem_data_ok = 1'b1;
            @(negedge clk);
        end
        mem_data_ok = 1'b0;
    endtask

    task automatic serve_write();
        wait_latency();
        mem_addr_ok_w = 1'b1;
        store[{mem_addr_w[31:4], 4'h0}] = mem_wdata;
        last_wb_addr  = mem_addr_w;
        last_wb_line  = mem_wdata;
        wb_count++;
        send_data_ok();
    endtask

    task automatic serve_read();
        logic [31:0] base;
        wait_latency();
        base          = {mem_addr_r[31:4], 4'h0};
        mem_addr_ok_r = 1'b1;
        if (store.exists(base)) begin
            mem_rdata = store[base];
        end else begin
            mem_rdata = unwritten_line(base);
        end
        rd_count++;
        send_data_ok();
    endtask

    initial begin
        rng           = 32'd25711;
        mem_addr_ok_r = 1'b0;
        mem_addr_ok_w = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rdata     = '0;
        rd_count      = 0;
        wb_count      = 0;
        last_wb_addr  = '0;
        last_wb_line  = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req_w) begin
                serve_write();
            end else if (rst_n && mem_req_r) begin
                serve_read();
            end
        end
    end

endmodule

// ==== verif/l2cache_tb.sv ====
`timescale 1ns/1ps

module l2cache_tb import l2cache_pkg::*; ();

    localparam int NUM_ROWS = 21;
    localparam int TIMEOUT  = NUM_ROWS * 40 + 100;

    typedef struct packed {
        req_src_t    src;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        line_t       exp_line;
        logic        dual;
        logic [31:0] iaddr;
        line_t       exp_iline;
        int          exp_rd;
        int          exp_wb;
        logic        wb_chk;
        logic [31:0] wb_addr;
        line_t       wb_line;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        icache_req;
    logic [31:0] icache_addr;
    logic        icache_addr_ok;
    logic        icache_data_ok;
    line_t       icache_rdata;
    logic        dcache_req;
    l1_req_t     dcache_info;
    logic        dcache_addr_ok;
    logic        dcache_data_ok;
    line_t       dcache_rdata;
    logic        mem_req_r;
    logic [31:0] mem_addr_r;
    logic        mem_addr_ok_r;
    logic        mem_req_w;
    logic [31:0] mem_addr_w;
    line_t       mem_wdata;
    logic        mem_addr_ok_w;
    logic        mem_data_ok;
    line_t       mem_rdata;
    int          rd_count;
    int          wb_count;
    logic [31:0] last_wb_addr;
    line_t       last_wb_line;

    row_t  rows [NUM_ROWS];
    string row_name [NUM_ROWS];
    int    nrows  = 0;
    int    errors = 0;
    int    checks = 0;

    // strobes captured at the rising edge and read at the falling edge
    int    cyc      = 0;
    logic  daok_q   = 1'b0;
    logic  iaok_q   = 1'b0;
    logic  ddok_q   = 1'b0;
    logic  idok_q   = 1'b0;
    line_t d_line_q = '0;
    line_t i_line_q = '0;

    l2cache #(
        .index_width (2)
    ) l2cache_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .icache_req     (icache_req),
        .icache_addr    (icache_addr),
        .icache_addr_ok (icache_addr_ok),
        .icache_data_ok (icache_data_ok),
        .icache_rdata   (icache_rdata),
        .dcache_req     (dcache_req),
        .dcache_info    (dcache_info),
        .dcache_addr_ok (dcache_addr_ok),
        .dcache_data_ok (dcache_data_ok),
        .dcache_rdata   (dcache_rdata),
        .mem_req_r      (mem_req_r),
        .mem_addr_r     (mem_addr_r),
        .mem_addr_ok_r  (mem_addr_ok_r),
        .mem_req_w      (mem_req_w),
        .mem_addr_w     (mem_addr_w),
        .mem_wdata      (mem_wdata),
        .mem_addr_ok_w  (mem_addr_ok_w),
        .mem_data_ok    (mem_data_ok),
        .mem_rdata      (mem_rdata)
    );

    l2cache_mem_model mem_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_req_r     (mem_req_r),
        .mem_addr_r    (mem_addr_r),
        .mem_addr_ok_r (mem_addr_ok_r),
        .mem_req_w     (mem_req_w),
        .mem_addr_w    (mem_addr_w),
        .mem_wdata     (mem_wdata),
        .mem_addr_ok_w (mem_addr_ok_w),
        .mem_data_ok   (mem_data_ok),
        .mem_rdata     (mem_rdata),
        .rd_count      (rd_count),
        .wb_count      (wb_count),
        .last_wb_addr  (last_wb_addr),
        .last_wb_line  (last_wb_line)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cyc    <= cyc + 1;
        daok_q <= dcache_addr_ok;
        iaok_q <= icache_addr_ok;
        ddok_q <= dcache_data_ok;
        idok_q <= icache_data_ok;
        if (dcache_data_ok) begin
            d_line_q <= dcache_rdata;
        end
        if (icache_data_ok) begin
            i_line_q <= icache_rdata;
        end
        if (cyc >= TIMEOUT) begin
            $display("timeout: the cache did not finish the table within %0d cycles", cyc);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // unwritten line holds each word address xor 0x5A5A0000
    function automatic line_t pattern_line(input logic [31:0] addr);
        line_t       l;
        logic [31:0] base;
        base = {addr[31:4], 4'h0};
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w] = (base + 32'(w * 4)) ^ 32'h5A5A_0000;
        end
        return l;
    endfunction

    function automatic line_t set_word(input line_t l, input int w, input logic [31:0] v);
        line_t r;
        r    = l;
        r[w] = v;
        return r;
    endfunction

    task automatic check_line(input string what, input line_t got, input line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_grant(input req_src_t got, input req_src_t exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error at %0d ns: grant went to %s, expected %s",
                     $time, got.name(), exp.name());
        end
    endtask

    task automatic add_row(input string name, input req_src_t src, input logic wr,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb, input line_t exp_line,
                           input int exp_rd, input int exp_wb);
        row_t r;
        r          = '0;
        r.src      = src;
        r.wr       = wr;
        r.addr     = addr;
        r.wdata    = wdata;
        r.wstrb    = wstrb;
        r.exp_line = exp_line;
        r.exp_rd   = exp_rd;
        r.exp_wb   = exp_wb;
        rows[nrows]     = r;
        row_name[nrows] = name;
        nrows++;
    endtask

    // instruction fetch raised in the same cycle as the row's data request
    task automatic add_second(input logic [31:0] iaddr, input line_t exp_iline);
        rows[nrows-1].dual      = 1'b1;
        rows[nrows-1].iaddr     = iaddr;
        rows[nrows-1].exp_iline = exp_iline;
    endtask

    task automatic expect_writeback(input logic [31:0] addr, input line_t line);
        rows[nrows-1].wb_chk  = 1'b1;
        rows[nrows-1].wb_addr = addr;
        rows[nrows-1].wb_line = line;
    endtask

    task automatic build_table();
        line_t l2020;
        line_t l3030;
        line_t l4030;
        l2020 = set_word(pattern_line(32'h2020), 1, 32'h5AB2_20D4);
        l3030 = set_word(pattern_line(32'h3030), 0, 32'hDEAD_BEEF);
        l4030 = set_word(pattern_line(32'h4030), 1, 32'h5A5A_CAFE);
        add_row("read miss", SRC_DATA, 1'b0, 32'h1010, '0, 4'h0,
                pattern_line(32'h1010), 1, 0);
        add_row("read hit", SRC_DATA, 1'b0, 32'h1018, '0, 4'h0,
                pattern_line(32'h1010), 0, 0);
        // bytes 0 and 2 of word 1 in set 2
        add_row("write miss", SRC_DATA, 1'b1, 32'h2024, 32'hA1B2_C3D4, 4'h5, '0, 1, 0);
        add_row("strobed read", SRC_DATA, 1'b0, 32'h2020, '0, 4'h0, l2020, 0, 0);
        add_row("write hit", SRC_DATA, 1'b1, 32'h2028, 32'h1122_3344, 4'h8, '0, 0, 0);
        add_row("merged read", SRC_DATA, 1'b0, 32'h202C, '0, 4'h0,
                set_word(l2020, 2, 32'h115A_2028), 0, 0);
        // set 3 fills ways 2 and 3 and then evicts the older one
        add_row("fill way 2", SRC_DATA, 1'b1, 32'h3030, 32'hDEAD_BEEF, 4'hF, '0, 1, 0);
        add_row("fill way 3", SRC_DATA, 1'b1, 32'h4034, 32'h0000_CAFE, 4'h3, '0, 1, 0);
        add_row("dirty eviction", SRC_DATA, 1'b1, 32'h5038, 32'h7766_5544, 4'hC, '0, 1, 1);
        expect_writeback(32'h3030, l3030);
        add_row("evicted line back", SRC_DATA, 1'b0, 32'h3030, '0, 4'h0, l3030, 1, 1);
        expect_writeback(32'h4030, l4030);
        // set 0 with two lines per half, then a third data line replaces way 2 only
        add_row("inst fill way 0", SRC_INST, 1'b0, 32'h6000, '0, 4'h0,
                pattern_line(32'h6000), 1, 0);
        add_row("inst fill way 1", SRC_INST, 1'b0, 32'h7004, '0, 4'h0,
                pattern_line(32'h7000), 1, 0);
        add_row("data fill way 2", SRC_DATA, 1'b0, 32'h8008, '0, 4'h0,
                pattern_line(32'h8000), 1, 0);
        add_row("data fill way 3", SRC_DATA, 1'b0, 32'h900C, '0, 4'h0,
                pattern_line(32'h9000), 1, 0);
        add_row("third data line", SRC_DATA, 1'b0, 32'hC000, '0, 4'h0,
                pattern_line(32'hC000), 1, 0);
        add_row("inst way 0 kept", SRC_INST, 1'b0, 32'h6000, '0, 4'h0,
                pattern_line(32'h6000), 0, 0);
        add_row("inst way 1 kept", SRC_INST, 1'b0, 32'h7000, '0, 4'h0,
                pattern_line(32'h7000), 0, 0);
        add_row("data way 2 kept", SRC_DATA, 1'b0, 32'hC000, '0, 4'h0,
                pattern_line(32'hC000), 0, 0);
        add_row("data way 3 kept", SRC_DATA, 1'b0, 32'h9000, '0, 4'h0,
                pattern_line(32'h9000), 0, 0);
        add_row("priority on hits", SRC_DATA, 1'b0, 32'hC004, '0, 4'h0,
                pattern_line(32'hC000), 0, 0);
        add_second(32'h6008, pattern_line(32'h6000));
        add_row("priority on misses", SRC_DATA, 1'b0, 32'hA010, '0, 4'h0,
                pattern_line(32'hA010), 2, 0);
        add_second(32'hB020, pattern_line(32'hB020));
    endtask

    task automatic run_row(input int n);
        row_t     r;
        int       rd_start;
        int       wb_start;
        int       err_start;
        int       t_daok;
        int       t_ddok;
        int       t_iaok;
        int       t_idok;
        logic     d_busy;
        logic     i_busy;
        line_t    d_line;
        line_t    i_line;
        req_src_t grants [$];
        r         = rows[n];
        rd_start  = rd_count;
        wb_start  = wb_count;
        err_start = errors;
        t_daok    = 0;
        t_ddok    = 0;
        t_iaok    = 0;
        t_idok    = 0;
        d_line    = '0;
        i_line    = '0;
        d_busy    = r.dual || (r.src == SRC_DATA);
        i_busy    = r.dual || (r.src == SRC_INST);
        if (d_busy) begin
            dcache_info = '{wr: r.wr, addr: r.addr, wdata: r.wdata, wstrb: r.wstrb};
            dcache_req  = 1'b1;
        end
        if (i_busy) begin
            icache_addr = r.dual ? r.iaddr : r.addr;
            icache_req  = 1'b1;
        end
        while (d_busy || i_busy) begin
            @(negedge clk);
            if (daok_q) begin
                dcache_req = 1'b0;
                t_daok     = cyc;
                grants.push_back(SRC_DATA);
            end
            if (iaok_q) begin
                icache_req = 1'b0;
                t_iaok     = cyc;
                grants.push_back(SRC_INST);
            end
            if (ddok_q) begin
                d_busy = 1'b0;
                t_ddok = cyc;
                d_line = d_line_q;
            end
            if (idok_q) begin
                i_busy = 1'b0;
                t_idok = cyc;
                i_line = i_line_q;
            end
        end
        if (r.dual) begin
            if (grants.size() != 2 || t_daok == t_iaok) begin
                errors++;
                $display("the two requests were not granted one after the other");
            end else begin
                check_grant(grants[0], SRC_DATA);
                check_grant(grants[1], SRC_INST);
            end
            check_line("data line", d_line, r.exp_line);
            check_line("instruction line", i_line, r.exp_iline);
        end else if (!r.wr) begin
            check_line("read line", (r.src == SRC_DATA) ? d_line : i_line, r.exp_line);
        end
        check_count("memory reads", rd_count - rd_start, r.exp_rd);
        check_count("write-backs", wb_count - wb_start, r.exp_wb);
        if (r.wb_chk) begin
            check_addr("write-back address", last_wb_addr, r.wb_addr);
            check_line("write-back line", last_wb_line, r.wb_line);
        end
        // a hit answers 2 cycles after addr_ok
        if (r.exp_rd == 0 && r.exp_wb == 0) begin
            if (r.dual || r.src == SRC_DATA) begin
                check_count("data hit latency", t_ddok - t_daok, 2);
            end
            if (r.dual || r.src == SRC_INST) begin
                check_count("instruction hit latency", t_idok - t_iaok, 2);
            end
        end
        if (errors == err_start) begin
            $display("row %0d %s: ok", n, row_name[n]);
        end else begin
            $display("row %0d %s: failed", n, row_name[n]);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        icache_req  = 1'b0;
        icache_addr = '0;
        dcache_req  = 1'b0;
        dcache_info = '0;
        build_table();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        // the first request waits out the set sweep
        for (int n = 0; n < nrows; n++) begin
            run_row(n);
        end
        $display("%0d rows, %0d checks, %0d errors", nrows, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
